//--- design/usb_out_data_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_out_consts.svh"

module usb_out_data_path (
  input  logic                        clk_48mhz_i,
  input  logic                        rst_ni,
  input  usb_out_pkg::rx_byte_t       rx_byte_i,
  input  logic                        data_phase_i,
  input  logic                        arm_i,
  input  logic [`USB_OUT_EP_W-1:0]    cur_ep_i,
  input  logic [`USB_OUT_NUM_EPS-1:0] ep_full_i,
  output usb_out_pkg::ep_put_t        put_o,
  output logic                        store_fail_o
);

  import usb_out_pkg::*;

  logic                      put_q;
  logic [7:0]                data_q;
  logic [`USB_OUT_PKT_W-1:0] offset_q;
  logic                      nak_q;
  logic                      advance;

  // Put strobe trails the received byte by one cycle
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      put_q <= 1'b0;
    end else begin
      put_q <= data_phase_i && rx_byte_i.put;
    end
  end

  always_ff @(posedge clk_48mhz_i) begin
    if (rx_byte_i.put) begin
      data_q <= rx_byte_i.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // NAK flag and put offset
  ////////////////////////////////////////////////////////////////////////////

  // Any byte landing on a full endpoint spoils the whole packet
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_q <= 1'b0;
    end else if (!data_phase_i) begin
      nak_q <= 1'b0;
    end else if (put_q && ep_full_i[cur_ep_i]) begin
      nak_q <= 1'b1;
    end
  end

  // Stop at all ones, bytes past max packet size are lost
  assign advance = put_q && !nak_q && !(&offset_q);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
    end else if (arm_i) begin
      offset_q <= '0;
    end else if (data_phase_i && advance) begin
      offset_q <= offset_q + 1'b1;
    end
  end

  assign store_fail_o = nak_q || ep_full_i[cur_ep_i];
  assign put_o        = '{put: put_q, offset: offset_q, data: data_q};

endmodule

`default_nettype wire

//--- design/usb_out_pe.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_out_consts.svh"

module usb_out_pe (
  input  logic                        clk_48mhz_i,
  input  logic                        rst_ni,
  input  logic                        link_reset_i,
  input  logic [6:0]                  dev_addr_i,
  input  usb_out_pkg::rx_pkt_t        rx_pkt_i,
  input  usb_out_pkg::rx_byte_t       rx_byte_i,
  input  usb_out_pkg::ep_cfg_t        ep_cfg_i,
  output usb_out_pkg::ep_put_t        put_o,
  output usb_out_pkg::xact_status_t   status_o,
  output usb_out_pkg::tx_req_t        tx_o,
  output logic [`USB_OUT_NUM_EPS-1:0] out_setup_o,
  output logic [`USB_OUT_NUM_EPS-1:0] data_toggle_o
);

  import usb_out_pkg::*;

  rx_dec_t                  dec;
  logic [`USB_OUT_EP_W-1:0] cur_ep;
  logic                     data_phase;
  logic                     arm;
  logic                     new_pkt_end;
  logic                     store_fail;
  logic                     bad_toggle;

  // Packet classification, purely combinational
  usb_out_rx_decode u_rx_decode (
    .rx_pkt_i   (rx_pkt_i),
    .dev_addr_i (dev_addr_i),
    .ep_cfg_i   (ep_cfg_i),
    .dec_o      (dec)
  );

  usb_out_toggle u_toggle (
    .clk_48mhz_i   (clk_48mhz_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .dec_i         (dec),
    .cur_ep_i      (cur_ep),
    .new_pkt_end_i (new_pkt_end),
    .bad_toggle_o  (bad_toggle),
    .data_toggle_o (data_toggle_o),
    .out_setup_o   (out_setup_o)
  );

  // Transaction sequencing and handshakes
  usb_out_xact_fsm u_xact_fsm (
    .clk_48mhz_i   (clk_48mhz_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .dec_i         (dec),
    .rx_start_i    (rx_pkt_i.pkt_start),
    .bad_toggle_i  (bad_toggle),
    .store_fail_i  (store_fail),
    .ep_cfg_i      (ep_cfg_i),
    .cur_ep_o      (cur_ep),
    .data_phase_o  (data_phase),
    .arm_o         (arm),
    .new_pkt_end_o (new_pkt_end),
    .status_o      (status_o),
    .tx_o          (tx_o)
  );

  usb_out_data_path u_data_path (
    .clk_48mhz_i  (clk_48mhz_i),
    .rst_ni       (rst_ni),
    .rx_byte_i    (rx_byte_i),
    .data_phase_i (data_phase),
    .arm_i        (arm),
    .cur_ep_i     (cur_ep),
    .ep_full_i    (ep_cfg_i.full),
    .put_o        (put_o),
    .store_fail_o (store_fail)
  );

endmodule

`default_nettype wire

//--- design/usb_out_pkg.sv
`default_nettype none

`include "usb_out_consts.svh"

package usb_out_pkg;

  // Packet level strobes and fields from the receive decoder
  typedef struct packed {
    logic       pkt_start;
    logic       pkt_end;
    logic       pkt_valid;
    logic [3:0] pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } rx_pkt_t;

  // One received payload byte
  typedef struct packed {
    logic       put;
    logic [7:0] data;
  } rx_byte_t;

  // Endpoint configuration, one bit per implemented endpoint
  typedef struct packed {
    logic [`USB_OUT_NUM_EPS-1:0] enabled;
    logic [`USB_OUT_NUM_EPS-1:0] control;
    logic [`USB_OUT_NUM_EPS-1:0] full;
    logic [`USB_OUT_NUM_EPS-1:0] stall;
  } ep_cfg_t;

  // Byte write towards the endpoint buffer
  typedef struct packed {
    logic                      put;
    logic [`USB_OUT_PKT_W-1:0] offset;
    logic [7:0]                data;
  } ep_put_t;

  // Transaction outcome strobes and the endpoint they refer to
  typedef struct packed {
    logic       newpkt;
    logic       acked;
    logic       rollback;
    logic [3:0] cur_ep;
  } xact_status_t;

  // Handshake request to the transmit path
  typedef struct packed {
    logic       start;
    logic [3:0] pid;
  } tx_req_t;

  // Decoded view of the packet ending this cycle
  typedef struct packed {
    logic                     out_tok;
    logic                     setup_tok;
    logic                     data_pkt;
    logic                     bad_pkt;
    logic                     ep_active;
    logic                     ep_control;
    logic [`USB_OUT_EP_W-1:0] ep_idx;
    logic                     data_pid_odd;
  } rx_dec_t;

endpackage

`default_nettype wire

//--- design/usb_out_rx_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_out_consts.svh"

module usb_out_rx_decode (
  input  usb_out_pkg::rx_pkt_t rx_pkt_i,
  input  logic [6:0]           dev_addr_i,
  input  usb_out_pkg::ep_cfg_t ep_cfg_i,
  output usb_out_pkg::rx_dec_t dec_o
);

  import usb_pid_pkg::*;
  import usb_out_pkg::*;

  usb_pid_e                 pid;
  usb_pid_type_e            pid_type;
  logic                     tok_rx;
  logic                     is_data;
  logic                     ep_in_hw;
  logic [`USB_OUT_EP_W-1:0] ep_idx;

  // Enum views of the raw PID
  assign pid      = usb_pid_e'(rx_pkt_i.pid);
  assign pid_type = usb_pid_type_e'(rx_pkt_i.pid[1:0]);

  // Good token addressed to this device
  assign tok_rx = rx_pkt_i.pkt_end && rx_pkt_i.pkt_valid &&
                  (pid_type == UsbPidTypeToken) && (rx_pkt_i.addr == dev_addr_i);

  assign is_data = (pid == UsbPidData0) || (pid == UsbPidData1);

  // Endpoints above the implemented range fold onto index 0
  assign ep_in_hw = {1'b0, rx_pkt_i.endp} < 5'(`USB_OUT_NUM_EPS);
  assign ep_idx   = ep_in_hw ? rx_pkt_i.endp[`USB_OUT_EP_W-1:0] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Decode result
  ////////////////////////////////////////////////////////////////////////////

  assign dec_o.out_tok   = tok_rx && (pid == UsbPidOut);
  assign dec_o.setup_tok = tok_rx && (pid == UsbPidSetup);
  assign dec_o.data_pkt  = rx_pkt_i.pkt_end && rx_pkt_i.pkt_valid && is_data;
  // Bad CRC or anything valid that is not data
  assign dec_o.bad_pkt   = rx_pkt_i.pkt_end && (!rx_pkt_i.pkt_valid || !is_data);

  // Folded index never counts as active
  assign dec_o.ep_active  = ep_cfg_i.enabled[ep_idx] && ep_in_hw;
  assign dec_o.ep_control = ep_cfg_i.control[ep_idx];
  assign dec_o.ep_idx     = ep_idx;
  // DATA1 has the top PID bit set
  assign dec_o.data_pid_odd = rx_pkt_i.pid[3];

endmodule

`default_nettype wire

//--- design/usb_out_toggle.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_out_consts.svh"

module usb_out_toggle (
  input  logic                        clk_48mhz_i,
  input  logic                        rst_ni,
  input  logic                        link_reset_i,
  input  usb_out_pkg::rx_dec_t        dec_i,
  input  logic [`USB_OUT_EP_W-1:0]    cur_ep_i,
  input  logic                        new_pkt_end_i,
  output logic                        bad_toggle_o,
  output logic [`USB_OUT_NUM_EPS-1:0] data_toggle_o,
  output logic [`USB_OUT_NUM_EPS-1:0] out_setup_o
);

  import usb_out_pkg::*;

  logic [`USB_OUT_NUM_EPS-1:0] toggle_q;
  logic [`USB_OUT_NUM_EPS-1:0] toggle_d;

  // SETUP restarts the sequence at DATA0
  // Accepted packet advances the current endpoint
  always_comb begin
    toggle_d = toggle_q;
    if (dec_i.setup_tok && dec_i.ep_active) begin
      toggle_d[dec_i.ep_idx] = 1'b0;
    end else if (new_pkt_end_i) begin
      toggle_d[cur_ep_i] = ~toggle_q[cur_ep_i];
    end
  end

  // Link reset wipes every endpoint
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      toggle_q <= '0;
    end else begin
      toggle_q <= toggle_d;
    end
  end

  // Flag follows the kind of the last token per endpoint
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_setup_o <= '0;
    end else if (dec_i.setup_tok && dec_i.ep_active) begin
      out_setup_o[dec_i.ep_idx] <= 1'b1;
    end else if (dec_i.out_tok && dec_i.ep_active) begin
      out_setup_o[dec_i.ep_idx] <= 1'b0;
    end
  end

  // Data PID parity against the stored toggle
  assign bad_toggle_o = dec_i.data_pkt && dec_i.ep_active &&
                        (dec_i.data_pid_odd != toggle_q[dec_i.ep_idx]);

  assign data_toggle_o = toggle_q;

endmodule

`default_nettype wire

//--- design/usb_out_xact_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_out_consts.svh"

module usb_out_xact_fsm (
  input  logic                       clk_48mhz_i,
  input  logic                       rst_ni,
  input  logic                       link_reset_i,
  input  usb_out_pkg::rx_dec_t       dec_i,
  input  logic                       rx_start_i,
  input  logic                       bad_toggle_i,
  input  logic                       store_fail_i,
  input  usb_out_pkg::ep_cfg_t       ep_cfg_i,
  output logic [`USB_OUT_EP_W-1:0]   cur_ep_o,
  output logic                       data_phase_o,
  output logic                       arm_o,
  output logic                       new_pkt_end_o,
  output usb_out_pkg::xact_status_t  status_o,
  output usb_out_pkg::tx_req_t       tx_o
);

  import usb_pid_pkg::*;
  import usb_out_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StRcvdOut,
    StRcvdDataStart,
    StRcvdDataEnd
  } xact_state_e;

  xact_state_e               state_q;
  xact_state_e               state_d;
  logic [`USB_OUT_TMO_W-1:0] tmo_q;
  logic [`USB_OUT_TMO_W-1:0] tmo_d;
  logic                      xact_start;
  logic                      newpkt_q;
  logic [`USB_OUT_EP_W-1:0]  cur_ep_q;
  // 1 for SETUP, 0 for OUT
  logic                      setup_q;
  logic                      acked;
  logic                      rollback;
  logic                      tx_start;
  logic [3:0]                tx_pid;
  logic                      ep_stalled;

  assign ep_stalled = ep_cfg_i.stall[cur_ep_q];

  ////////////////////////////////////////////////////////////////////////////
  // Next state and handshake choice
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    tmo_d         = `USB_OUT_TMO_W'(`USB_OUT_ACK_TIMEOUT);
    xact_start    = 1'b0;
    acked         = 1'b0;
    rollback      = 1'b0;
    tx_start      = 1'b0;
    tx_pid        = 4'b0000;
    new_pkt_end_o = 1'b0;

    unique case (state_q)
      StIdle: begin
        // SETUP only counts on a control endpoint
        if (dec_i.ep_active &&
            (dec_i.out_tok || (dec_i.setup_tok && dec_i.ep_control))) begin
          state_d    = StRcvdOut;
          xact_start = 1'b1;
        end
      end

      StRcvdOut: begin
        // Host data must start before the counter runs out
        tmo_d = tmo_q - 1'b1;
        if (rx_start_i) begin
          state_d = StRcvdDataStart;
        end else if (tmo_q == '0) begin
          state_d = StIdle;
        end
      end

      StRcvdDataStart: begin
        if (bad_toggle_i && !ep_stalled) begin
          // Repeat of a packet we already took, so our ACK was lost
          state_d  = StIdle;
          rollback = 1'b1;
          tx_start = 1'b1;
          tx_pid   = UsbPidAck;
        end else if (dec_i.bad_pkt) begin
          // No answer at all on a corrupt packet
          state_d  = StIdle;
          rollback = 1'b1;
        end else if (dec_i.data_pkt) begin
          state_d = StRcvdDataEnd;
        end
      end

      StRcvdDataEnd: begin
        state_d  = StIdle;
        tx_start = 1'b1;
        if (setup_q) begin
          if (store_fail_i) begin
            // SETUP that cannot be stored is dropped silently
            tx_start = 1'b0;
            rollback = 1'b1;
          end else begin
            tx_pid        = UsbPidAck;
            acked         = 1'b1;
            new_pkt_end_o = 1'b1;
          end
        end else if (ep_stalled) begin
          tx_pid = UsbPidStall;
        end else if (store_fail_i) begin
          // Buffer busy, host retries later
          tx_pid   = UsbPidNak;
          rollback = 1'b1;
        end else begin
          tx_pid        = UsbPidAck;
          acked         = 1'b1;
          new_pkt_end_o = 1'b1;
        end
      end

      default: state_d = StIdle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State, timeout and transaction registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      tmo_q   <= `USB_OUT_TMO_W'(`USB_OUT_ACK_TIMEOUT);
    end else begin
      state_q <= link_reset_i ? StIdle : state_d;
      tmo_q   <= tmo_d;
    end
  end

  // Endpoint and kind latched when the token is taken
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      newpkt_q <= 1'b0;
      cur_ep_q <= '0;
      setup_q  <= 1'b0;
    end else begin
      newpkt_q <= xact_start;
      if (xact_start) begin
        cur_ep_q <= dec_i.ep_idx;
        setup_q  <= dec_i.setup_tok;
      end
    end
  end

  assign cur_ep_o     = cur_ep_q;
  assign arm_o        = (state_q == StRcvdOut);
  assign data_phase_o = (state_q == StRcvdDataStart);

  assign status_o = '{newpkt:   newpkt_q,
                      acked:    acked,
                      rollback: rollback,
                      cur_ep:   {{(4 - `USB_OUT_EP_W){1'b0}}, cur_ep_q}};
  assign tx_o     = '{start: tx_start, pid: tx_pid};

endmodule

`default_nettype wire

//--- design/usb_pid_pkg.sv
`default_nettype none

package usb_pid_pkg;

  // Low two bits of a PID give its class
  typedef enum logic [1:0] {
    UsbPidTypeSpecial   = 2'b00,
    UsbPidTypeToken     = 2'b01,
    UsbPidTypeHandshake = 2'b10,
    UsbPidTypeData      = 2'b11
  } usb_pid_type_e;

  // PIDs seen or sent by the OUT engine
  typedef enum logic [3:0] {
    UsbPidOut   = 4'b0001,
    UsbPidIn    = 4'b1001,
    UsbPidSetup = 4'b1101,
    UsbPidData0 = 4'b0011,
    UsbPidData1 = 4'b1011,
    UsbPidAck   = 4'b0010,
    UsbPidNak   = 4'b1010,
    UsbPidStall = 4'b1110
  } usb_pid_e;

endpackage

`default_nettype wire

//--- include/usb_out_consts.svh
`ifndef USB_OUT_CONSTS_SVH
`define USB_OUT_CONSTS_SVH

// Implemented OUT endpoints and the width of an index into them
`define USB_OUT_NUM_EPS 4
`define USB_OUT_EP_W 2

// Largest data payload a single OUT packet may carry
`define USB_OUT_MAX_PKT 32
// Put offset width, log2 of the max packet size
`define USB_OUT_PKT_W 5

// Wait for the host data packet, 17 bit times at 4 clocks per bit
`define USB_OUT_ACK_TIMEOUT 68
// Counter width, wide enough to hold the timeout load value
`define USB_OUT_TMO_W 7

`endif

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f usb_out_pe.f --top-module usb_out_pe_tb \
  --Mdir obj_dir -o sim_usb_out_pe > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_usb_out_pe > sim.log 2>&1

grep -q "Verification passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }

//--- tests/usb_out_pe_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module usb_out_pe_asserts (
  input logic                     clk_48mhz_i,
  input logic                     rst_ni,
  input usb_out_pkg::xact_status_t status_o,
  input usb_out_pkg::tx_req_t      tx_o,
  input usb_out_pkg::ep_put_t      put_o
);

  import usb_out_pkg::*;

  // High from newpkt until the first put of the packet
  logic first_put_q;

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_put_q <= 1'b0;
    end else if (status_o.newpkt) begin
      first_put_q <= 1'b1;
    end else if (put_o.put) begin
      first_put_q <= 1'b0;
    end
  end

  // Handshake never shares a cycle with the token pulse
  tx_vs_newpkt: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !(tx_o.start && status_o.newpkt))
    else $error("tx start together with newpkt");

  acked_vs_rollback: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !(status_o.acked && status_o.rollback))
    else $error("acked and rollback both high");

  first_put_offset: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    (put_o.put && first_put_q) |-> (put_o.offset == '0))
    else $error("first put of a packet has a nonzero offset");

endmodule

bind usb_out_pe usb_out_pe_asserts u_asserts (
  .clk_48mhz_i (clk_48mhz_i),
  .rst_ni      (rst_ni),
  .status_o    (status_o),
  .tx_o        (tx_o),
  .put_o       (put_o)
);

`default_nettype wire

//--- tests/usb_out_pe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_out_consts.svh"

module usb_out_pe_tb;

  import usb_pid_pkg::*;
  import usb_out_pkg::*;

  localparam logic [6:0] DEV_ADDR = 7'h2a;
  localparam int         NUM_PKTS = 24;

  // Expected answer to one data packet
  typedef struct packed {
    tx_req_t      tx;
    logic         now;
    xact_status_t st;
    logic         flip;
  } outcome_t;

  logic                        clk_48mhz;
  logic                        rst_n;
  logic                        link_reset;
  logic [6:0]                  dev_addr;
  rx_pkt_t                     rx_pkt;
  rx_byte_t                    rx_byte;
  ep_cfg_t                     ep_cfg;
  ep_put_t                     put;
  xact_status_t                status;
  tx_req_t                     tx;
  logic [`USB_OUT_NUM_EPS-1:0] out_setup;
  logic [`USB_OUT_NUM_EPS-1:0] data_toggle;

  int                          cyc;
  logic [31:0]                 rng_state;
  logic [`USB_OUT_NUM_EPS-1:0] model_toggle;
  logic [`USB_OUT_NUM_EPS-1:0] model_setup;

  // Expected strobes, each with the cycle it must show up in
  tx_req_t      exp_tx_q[$];
  int           exp_tx_cyc_q[$];
  xact_status_t exp_st_q[$];
  int           exp_st_cyc_q[$];
  ep_put_t      exp_put_q[$];
  int           exp_put_cyc_q[$];

  usb_out_pe UUT (
    .clk_48mhz_i   (clk_48mhz),
    .rst_ni        (rst_n),
    .link_reset_i  (link_reset),
    .dev_addr_i    (dev_addr),
    .rx_pkt_i      (rx_pkt),
    .rx_byte_i     (rx_byte),
    .ep_cfg_i      (ep_cfg),
    .put_o         (put),
    .status_o      (status),
    .tx_o          (tx),
    .out_setup_o   (out_setup),
    .data_toggle_o (data_toggle)
  );

  initial begin
    clk_48mhz = 1'b0;
    forever #2 clk_48mhz = ~clk_48mhz;
  end

  initial cyc = 0;
  always @(posedge clk_48mhz) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Strobes from the previous cycle drop here
  task automatic next_cycle();
    @(posedge clk_48mhz);
    #1;
    rx_pkt     = '0;
    rx_byte    = '0;
    link_reset = 1'b0;
  endtask

  task automatic check_tx(input tx_req_t got, input tx_req_t exp);
    if (got !== exp) report_error($sformatf("mismatch tx_o: got %h expected %h", got, exp));
  endtask

  task automatic check_status(input xact_status_t got, input xact_status_t exp);
    if (got !== exp) begin
      report_error($sformatf("mismatch status_o: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_put(input ep_put_t got, input ep_put_t exp);
    if (got !== exp) report_error($sformatf("mismatch put_o: got %h expected %h", got, exp));
  endtask

  task automatic check_offset(input logic [`USB_OUT_PKT_W-1:0] got,
                              input logic [`USB_OUT_PKT_W-1:0] exp);
    if (got !== exp) report_error($sformatf("mismatch put_o.offset: got %h expected %h", got, exp));
  endtask

  task automatic check_flags(input logic [`USB_OUT_NUM_EPS-1:0] got,
                             input logic [`USB_OUT_NUM_EPS-1:0] exp, input string name);
    if (got !== exp) report_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_cycle(input int exp_cyc, input string what);
    if (exp_cyc != cyc) begin
      report_error($sformatf("%s came in cycle %0d instead of cycle %0d", what, cyc, exp_cyc));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model of the handshake rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic outcome_t predict(input logic is_setup, input int ep,
                                       input logic pid_odd, input int bad_kind);
    outcome_t oc;
    logic     stalled;
    logic     full;
    oc        = '0;
    stalled   = ep_cfg.stall[ep];
    full      = ep_cfg.full[ep];
    oc.st.cur_ep = 4'(ep);
    if (bad_kind == 0 && pid_odd != model_toggle[ep] && !stalled) begin
      // Retried packet, ACK again but drop the data
      oc.now         = 1'b1;
      oc.tx          = '{start: 1'b1, pid: 4'(UsbPidAck)};
      oc.st.rollback = 1'b1;
    end else if (bad_kind != 0) begin
      oc.now         = 1'b1;
      oc.st.rollback = 1'b1;
    end else if (is_setup && full) begin
      oc.st.rollback = 1'b1;
    end else if (!is_setup && stalled) begin
      oc.tx = '{start: 1'b1, pid: 4'(UsbPidStall)};
    end else if (!is_setup && full) begin
      oc.tx          = '{start: 1'b1, pid: 4'(UsbPidNak)};
      oc.st.rollback = 1'b1;
    end else begin
      oc.tx       = '{start: 1'b1, pid: 4'(UsbPidAck)};
      oc.st.acked = 1'b1;
      oc.flip     = 1'b1;
    end
    return oc;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Comparing process, sampled at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_48mhz) begin
    if (rst_n) begin
      if (tx.start) begin
        if (exp_tx_q.size() == 0) report_error("transmit request that no packet called for");
        check_cycle(exp_tx_cyc_q.pop_front(), "transmit request");
        check_tx(tx, exp_tx_q.pop_front());
      end
      if (status.newpkt || status.acked || status.rollback) begin
        if (exp_st_q.size() == 0) report_error("status strobe that no packet called for");
        check_cycle(exp_st_cyc_q.pop_front(), "status strobe");
        check_status(status, exp_st_q.pop_front());
      end
      if (put.put) begin
        if (exp_put_q.size() == 0) report_error("byte put that no packet called for");
        check_cycle(exp_put_cyc_q.pop_front(), "byte put");
        check_put(put, exp_put_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Packet stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Token, then optionally rx start, bytes and the data end
  task automatic run_xact(input logic is_setup, input logic [6:0] addr, input logic [3:0] endp,
                          input logic pid_odd, input int nbytes, input int bad_kind,
                          input logic late);
    int           ep;
    int           t0;
    int           te;
    int           off;
    logic         active;
    logic         starts;
    logic         full;
    logic [7:0]   b;
    outcome_t     oc;
    xact_status_t st_exp;
    ep_put_t      put_exp;
    ep      = (endp < 4'(`USB_OUT_NUM_EPS)) ? int'(endp) : 0;
    active  = (addr == DEV_ADDR) && (endp < 4'(`USB_OUT_NUM_EPS)) && ep_cfg.enabled[ep];
    starts  = active && (!is_setup || ep_cfg.control[ep]);
    full    = ep_cfg.full[ep];
    next_cycle();
    t0 = cyc;
    rx_pkt = '{pkt_start: 1'b0, pkt_end: 1'b1, pkt_valid: 1'b1,
               pid: is_setup ? 4'(UsbPidSetup) : 4'(UsbPidOut), addr: addr, endp: endp};
    if (active) begin
      if (is_setup) begin
        model_toggle[ep] = 1'b0;
        model_setup[ep]  = 1'b1;
      end else begin
        model_setup[ep] = 1'b0;
      end
    end
    if (starts) begin
      st_exp = '{newpkt: 1'b1, acked: 1'b0, rollback: 1'b0, cur_ep: 4'(ep)};
      exp_st_q.push_back(st_exp);
      exp_st_cyc_q.push_back(t0 + 1);
    end
    next_cycle();
    if (starts) begin
      // Past the ACK timeout the engine is back in idle
      if (late) repeat (80) next_cycle();
      next_cycle();
      rx_pkt.pkt_start = 1'b1;
      for (int i = 0; i < nbytes; i++) begin
        next_cycle();
        b       = 8'(rand32());
        rx_byte = '{put: 1'b1, data: b};
        off     = full ? ((i < 1) ? i : 1) : ((i < 31) ? i : 31);
        if (!late) begin
          put_exp = '{put: 1'b1, offset: 5'(off), data: b};
          exp_put_q.push_back(put_exp);
          exp_put_cyc_q.push_back(cyc + 1);
        end
      end
      next_cycle();
      te = cyc;
      rx_pkt = '{pkt_start: 1'b0, pkt_end: 1'b1, pkt_valid: (bad_kind != 1),
                 pid: (bad_kind == 2) ? 4'(UsbPidAck) :
                      (pid_odd ? 4'(UsbPidData1) : 4'(UsbPidData0)),
                 addr: addr, endp: endp};
      if (!late) begin
        oc = predict(is_setup, ep, pid_odd, bad_kind);
        if (oc.tx.start) begin
          exp_tx_q.push_back(oc.tx);
          exp_tx_cyc_q.push_back(oc.now ? te : te + 1);
        end
        if (oc.st.acked || oc.st.rollback) begin
          exp_st_q.push_back(oc.st);
          exp_st_cyc_q.push_back(oc.now ? te : te + 1);
        end
        if (oc.flip) model_toggle[ep] = ~model_toggle[ep];
      end
    end
    repeat (3) next_cycle();
    check_flags(data_toggle, model_toggle, "data_toggle_o");
    check_flags(out_setup, model_setup, "out_setup_o");
  endtask

  task automatic pulse_link_reset();
    next_cycle();
    link_reset = 1'b1;
    model_toggle = '0;
    repeat (2) next_cycle();
    check_flags(data_toggle, '0, "data_toggle_o");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog and main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    repeat (NUM_PKTS * 200) @(posedge clk_48mhz);
    report_error("watchdog expired before the test sequence finished");
  end

  initial begin
    int ep;
    rng_state    = 32'hcfd6_6c8c;
    model_toggle = '0;
    model_setup  = '0;
    rst_n        = 1'b0;
    link_reset   = 1'b0;
    dev_addr     = DEV_ADDR;
    rx_pkt       = '0;
    rx_byte      = '0;
    ep_cfg       = '{enabled: 4'b1011, control: 4'b0001, full: 4'b0000, stall: 4'b0000};
    repeat (10) @(posedge clk_48mhz);
    #1;
    rst_n = 1'b1;
    next_cycle();
    check_flags(data_toggle, '0, "data_toggle_o");
    check_flags(out_setup, '0, "out_setup_o");
    check_offset(put.offset, '0);

    // Good OUT packets on the enabled bulk endpoints
    for (int k = 0; k < 8; k++) begin
      ep = int'(rand32() % 3);
      if (ep == 2) ep = 3;
      run_xact(1'b0, DEV_ADDR, 4'(ep), model_toggle[ep], 1 + int'(rand32() % 8), 0, 1'b0);
    end
    // Offset saturates at the max packet size
    run_xact(1'b0, DEV_ADDR, 4'd1, model_toggle[1], 33, 0, 1'b0);

    run_xact(1'b0, DEV_ADDR, 4'd1, ~model_toggle[1], 4, 0, 1'b0);

    ep_cfg.full[3] = 1'b1;
    run_xact(1'b0, DEV_ADDR, 4'd3, model_toggle[3], 3, 0, 1'b0);
    ep_cfg.full[3]  = 1'b0;
    ep_cfg.stall[1] = 1'b1;
    run_xact(1'b0, DEV_ADDR, 4'd1, model_toggle[1], 2, 0, 1'b0);
    ep_cfg.stall[1] = 1'b0;

    // SETUP on the control endpoint, then on a bulk one
    run_xact(1'b1, DEV_ADDR, 4'd0, 1'b0, 8, 0, 1'b0);
    run_xact(1'b1, DEV_ADDR, 4'd1, 1'b0, 0, 0, 1'b0);
    run_xact(1'b0, DEV_ADDR, 4'd0, model_toggle[0], 2, 0, 1'b0);

    run_xact(1'b0, 7'h11, 4'd0, model_toggle[0], 0, 0, 1'b0);
    run_xact(1'b0, DEV_ADDR, 4'd2, 1'b0, 0, 0, 1'b0);
    run_xact(1'b0, DEV_ADDR, 4'd9, 1'b0, 0, 0, 1'b0);
    run_xact(1'b0, DEV_ADDR, 4'd3, model_toggle[3], 4, 0, 1'b1);

    run_xact(1'b0, DEV_ADDR, 4'd0, model_toggle[0], 2, 1, 1'b0);
    run_xact(1'b0, DEV_ADDR, 4'd3, model_toggle[3], 2, 2, 1'b0);
    // Endpoint 1 sits at DATA0 since its SETUP, so this leaves a set toggle
    run_xact(1'b0, DEV_ADDR, 4'd1, model_toggle[1], 3, 0, 1'b0);
    pulse_link_reset();

    repeat (5) next_cycle();
    if (exp_tx_q.size() != 0 || exp_st_q.size() != 0 || exp_put_q.size() != 0) begin
      report_error("an expected output never appeared");
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- usb_out_pe.f
+incdir+include
design/usb_pid_pkg.sv
design/usb_out_pkg.sv
design/usb_out_rx_decode.sv
design/usb_out_toggle.sv
design/usb_out_xact_fsm.sv
design/usb_out_data_path.sv
design/usb_out_pe.sv
tests/usb_out_pe_asserts.sv
tests/usb_out_pe_tb.sv
